/* filelist.f */
+incdir+hdl
hdl/frontEndPkg.sv
hdl/decodeIf.sv
hdl/instrMemory.sv
hdl/decodeUnit.sv
hdl/renameUnit.sv
hdl/cpuFrontEnd.sv
verif/cpuFrontEndTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module cpuFrontEndTb \
    -o simFrontEnd

./obj_dir/simFrontEnd | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* verif/cpuFrontEndTb.sv */
`timescale 1ns/1ps
`include "frontEnd_defs.svh"

module cpuFrontEndTb;

    localparam int NUM_PROGS   = 12;
    localparam int LOAD_CYCLES = `IMEM_DEPTH + 2;
    localparam int LIMIT_CYCLES = 10 + NUM_PROGS * (40 + LOAD_CYCLES);

    logic                    clk;
    logic                    reset;
    logic                    loadEn;
    logic [`IMEM_ADDR_W-1:0] loadAddr;
    logic [31:0]             loadData;
    logic                    start;
    logic                    wbValid;
    logic [`PHYS_W-1:0]      wbPhys;
    logic                    renValid;
    logic [31:0]             renPc;
    logic [`PHYS_W-1:0]      srcPhys1;
    logic [`PHYS_W-1:0]      srcPhys2;
    logic [`PHYS_W-1:0]      destPhys;
    logic                    src1Ready;
    logic                    src2Ready;
    logic [31:0]             renImm;
    frontEndPkg::aluOpE      renAluOp;
    logic                    renIllegal;
    logic                    done;

    integer seed = 32'h9b69_cf69;
    int     errorCount;
    int     progNum;
    int     progLen;
    logic [31:0] prog [`IMEM_DEPTH];

    // Reference rename state
    logic [`PHYS_W-1:0]    aliasM [`ARCH_REGS];
    logic [`PHYS_REGS-1:0] readyM;
    int                    allocCount;  // Free-list pops so far
    logic                  allocValid;
    logic [`ARCH_W-1:0]    allocRd;
    logic [`PHYS_W-1:0]    allocPhys;

    cpuFrontEnd dut_i (
        .clk        (clk),
        .reset      (reset),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .start      (start),
        .wbValid    (wbValid),
        .wbPhys     (wbPhys),
        .renValid   (renValid),
        .renPc      (renPc),
        .srcPhys1   (srcPhys1),
        .srcPhys2   (srcPhys2),
        .destPhys   (destPhys),
        .src1Ready  (src1Ready),
        .src2Ready  (src2Ready),
        .renImm     (renImm),
        .renAluOp   (renAluOp),
        .renIllegal (renIllegal),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Ends a run that never reaches done
    initial begin
        #(LIMIT_CYCLES * 10);
        $display("Timeout: the front end did not finish all programs in %0d cycles",
                 LIMIT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Simulation timed out");
    end

    function automatic string label(input int idx, input string field);
        return $sformatf("prog%0d idx%0d %s", progNum, idx, field);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] randomInstr();
        logic [31:0] w;
        logic [3:0]  pick;
        logic [6:0]  opc;
        w    = $random(seed);
        pick = 4'($random(seed));
        opc  = 7'($random(seed));
        case (pick)
            0, 1, 2:  w[6:0] = frontEndPkg::OP;
            3, 4, 5:  w[6:0] = frontEndPkg::OPIMM;
            6, 7:     w[6:0] = frontEndPkg::LOAD;
            8, 9:     w[6:0] = frontEndPkg::STORE;
            10, 11:   w[6:0] = frontEndPkg::BRANCH;
            12, 13:   w[6:0] = frontEndPkg::LUI;
            14:       w[6:0] = frontEndPkg::OP;
            default: begin
                // Random illegal opcode that keeps the word nonzero
                if (opc inside {7'h00, frontEndPkg::OP, frontEndPkg::OPIMM, frontEndPkg::LOAD,
                                frontEndPkg::STORE, frontEndPkg::BRANCH, frontEndPkg::LUI}) begin
                    opc = 7'h7f;
                end
                w[6:0] = opc;
            end
        endcase
        return w;
    endfunction

    // Expected decode straight from the RV32I bit layout
    task automatic decodeWord(input logic [31:0] w, output logic [31:0] imm,
                              output logic [1:0] aluOp, output logic useRs2,
                              output logic regWrite, output logic illegal);
        imm      = 32'b0;
        aluOp    = frontEndPkg::ADD;
        useRs2   = 1'b0;
        regWrite = 1'b0;
        illegal  = 1'b0;
        case (w[6:0])
            frontEndPkg::OP: begin
                aluOp    = frontEndPkg::FUNCT;
                useRs2   = 1'b1;
                regWrite = 1'b1;
            end
            frontEndPkg::OPIMM: begin
                imm      = {{20{w[31]}}, w[31:20]};
                aluOp    = frontEndPkg::FUNCT;
                regWrite = 1'b1;
            end
            frontEndPkg::LOAD: begin
                imm      = {{20{w[31]}}, w[31:20]};
                regWrite = 1'b1;
            end
            frontEndPkg::STORE: begin
                imm    = {{20{w[31]}}, w[31:25], w[11:7]};
                useRs2 = 1'b1;
            end
            frontEndPkg::BRANCH: begin
                imm    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                aluOp  = frontEndPkg::SUB;
                useRs2 = 1'b1;
            end
            frontEndPkg::LUI: begin
                imm      = {w[31:12], 12'b0};
                regWrite = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    endtask

    task automatic renameAndCheck(input int k);
        logic [31:0]        w;
        logic [31:0]        imm;
        logic [1:0]         aluOp;
        logic               useRs2;
        logic               regWrite;
        logic               illegal;
        logic [`PHYS_W-1:0] p1;
        logic [`PHYS_W-1:0] p2;
        logic               r1;
        logic               r2;
        w = prog[k];
        decodeWord(w, imm, aluOp, useRs2, regWrite, illegal);
        p1 = aliasM[w[19:15]];
        r1 = readyM[p1];
        p2 = useRs2 ? aliasM[w[24:20]] : '0;
        r2 = useRs2 ? readyM[p2] : 1'b1;
        allocValid = regWrite && (w[11:7] != 5'd0);
        allocRd    = w[11:7];
        allocPhys  = allocValid ? `PHYS_W'(`ARCH_REGS + allocCount % `FREE_DEPTH) : '0;
        checkValue(label(k, "renPc"), 32'(k * 4), renPc);
        checkValue(label(k, "renImm"), imm, renImm);
        checkValue(label(k, "renAluOp"), 32'(aluOp), 32'(renAluOp));
        checkValue(label(k, "renIllegal"), 32'(illegal), 32'(renIllegal));
        checkValue(label(k, "srcPhys1"), 32'(p1), 32'(srcPhys1));
        checkValue(label(k, "src1Ready"), 32'(r1), 32'(src1Ready));
        checkValue(label(k, "srcPhys2"), 32'(p2), 32'(srcPhys2));
        checkValue(label(k, "src2Ready"), 32'(r2), 32'(src2Ready));
        checkValue(label(k, "destPhys"), 32'(allocPhys), 32'(destPhys));
    endtask

    task automatic buildProgram();
        if (progNum % 4 == 3) begin
            progLen = `IMEM_DEPTH; // No stop word so fetch runs off the end
        end else begin
            progLen = 1 + int'($unsigned($random(seed)) % 31);
        end
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            prog[a] = randomInstr();
        end
        if (progLen < `IMEM_DEPTH) begin
            prog[progLen] = 32'b0;
        end
    endtask

    task automatic loadProgram();
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            @(negedge clk);
            checkValue(label(a, "done held"), 32'(progNum > 0), 32'(done));
            loadEn   = 1'b1;
            loadAddr = `IMEM_ADDR_W'(a);
            loadData = prog[a];
        end
    endtask

    task automatic runProgram();
        int   cyc;
        logic doneSeen;
        @(negedge clk);
        loadEn = 1'b0;
        start  = 1'b1;
        cyc      = -1;
        doneSeen = 1'b0;
        while (!doneSeen) begin
            @(negedge clk);
            start = 1'b0;
            cyc++;
            checkValue(label(cyc, "renValid"), 32'((cyc >= 3) && (cyc < progLen + 3)),
                       32'(renValid));
            allocValid = 1'b0;
            if (renValid) begin
                renameAndCheck(cyc - 3);
            end
            // Allocation from the same edge overrides the wakeup
            if (wbValid) begin
                readyM[wbPhys] = 1'b1;
            end
            if (allocValid) begin
                aliasM[allocRd]   = allocPhys;
                readyM[allocPhys] = 1'b0;
                allocCount++;
            end
            checkValue(label(cyc, "done"), 32'(cyc >= progLen + 3), 32'(done));
            doneSeen = done;
            wbValid  = ($random(seed) % 2) != 0;
            wbPhys   = {1'b1, 5'($random(seed))};
        end
        wbValid = 1'b0;
    endtask

    initial begin
        reset      = 1'b1;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = 32'b0;
        start      = 1'b0;
        wbValid    = 1'b0;
        wbPhys     = '0;
        errorCount = 0;
        allocCount = 0;
        allocValid = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            aliasM[i] = `PHYS_W'(i);
        end
        readyM = '1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkValue("reset renValid", 32'b0, 32'(renValid));
        checkValue("reset done", 32'b0, 32'(done));

        // Programs run back to back and share rename state
        for (progNum = 0; progNum < NUM_PROGS; progNum++) begin
            buildProgram();
            loadProgram();
            runProgram();
        end

        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/cpuFrontEnd.sv */
`timescale 1ns/1ps
`include "frontEnd_defs.svh"

module cpuFrontEnd (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    loadEn,
    input  logic [`IMEM_ADDR_W-1:0] loadAddr,
    input  logic [31:0]             loadData,
    input  logic                    start,
    input  logic                    wbValid,
    input  logic [`PHYS_W-1:0]      wbPhys,
    output logic                    renValid,
    output logic [31:0]             renPc,
    output logic [`PHYS_W-1:0]      srcPhys1,
    output logic [`PHYS_W-1:0]      srcPhys2,
    output logic [`PHYS_W-1:0]      destPhys,
    output logic                    src1Ready,
    output logic                    src2Ready,
    output logic [31:0]             renImm,
    output frontEndPkg::aluOpE      renAluOp,
    output logic                    renIllegal,
    output logic                    done
);

    logic [`IMEM_ADDR_W-1:0] fetchAddr;
    logic [31:0]             fetchWord;
    logic                    running;
    logic                    busy;      // A program was started and has not finished

    decodeIf decBus ();

    instrMemory imem_i (
        .clk       (clk),
        .reset     (reset),
        .loadEn    (loadEn && !running), // No loads while fetching
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .fetchAddr (fetchAddr),
        .fetchWord (fetchWord)
    );

    decodeUnit decode_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .fetchWord (fetchWord),
        .fetchAddr (fetchAddr),
        .running   (running),
        .dec       (decBus)
    );

    renameUnit rename_i (
        .clk        (clk),
        .reset      (reset),
        .dec        (decBus),
        .wbValid    (wbValid),
        .wbPhys     (wbPhys),
        .renValid   (renValid),
        .src1Ready  (src1Ready),
        .src2Ready  (src2Ready),
        .srcPhys1   (srcPhys1),
        .srcPhys2   (srcPhys2),
        .destPhys   (destPhys),
        .renPc      (renPc),
        .renImm     (renImm),
        .renAluOp   (renAluOp),
        .renIllegal (renIllegal)
    );

    // Done once fetch has stopped and the decode stage has drained
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy && !running && !decBus.valid) begin
            busy <= 1'b0;
            done <= 1'b1; // Last renValid was one cycle ago
        end
    end

endmodule

/* hdl/renameUnit.sv */
`timescale 1ns/1ps
`include "frontEnd_defs.svh"

module renameUnit (
    input  logic               clk,
    input  logic               reset,
    decodeIf.renamer           dec,
    input  logic               wbValid,
    input  logic [`PHYS_W-1:0] wbPhys,
    output logic               renValid,
    output logic               src1Ready,
    output logic               src2Ready,
    output logic [`PHYS_W-1:0] srcPhys1,
    output logic [`PHYS_W-1:0] srcPhys2,
    output logic [`PHYS_W-1:0] destPhys,
    output logic [31:0]        renPc,
    output logic [31:0]        renImm,
    output frontEndPkg::aluOpE renAluOp,
    output logic               renIllegal
);

    logic [`PHYS_W-1:0]  aliasTable [`ARCH_REGS];
    logic [`PHYS_W-1:0]  freeList [`FREE_DEPTH];
    logic [`FREE_W-1:0]  freeHead;             // Read pointer of the free list
    logic [`PHYS_REGS-1:0] readyBits;

    logic [`PHYS_W-1:0]  lookup1;
    logic [`PHYS_W-1:0]  lookup2;
    logic                ready1;
    logic                ready2;
    logic                doAlloc;
    logic [`PHYS_W-1:0]  newPhys;

    // Sources see the table before this instruction's own update
    assign lookup1 = aliasTable[dec.rs1];
    assign ready1  = readyBits[lookup1];
    assign lookup2 = dec.useRs2 ? aliasTable[dec.rs2] : '0;
    assign ready2  = dec.useRs2 ? readyBits[lookup2] : 1'b1; // Unused rs2 counts as ready

    assign doAlloc = dec.valid && dec.regWrite && (dec.rd != '0); // x0 never renamed
    assign newPhys = freeList[freeHead];

    // Alias table, free list and ready bits
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                aliasTable[i] <= `PHYS_W'(i); // Identity mapping
            end
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                freeList[i] <= `PHYS_W'(`ARCH_REGS + i);
            end
            freeHead  <= '0;
            readyBits <= '1;
        end else begin
            if (wbValid) begin
                readyBits[wbPhys] <= 1'b1;
            end
            if (doAlloc) begin
                aliasTable[dec.rd]  <= newPhys;
                readyBits[newPhys]  <= 1'b0; // Allocation wins over a wakeup of the same reg
                freeHead            <= freeHead + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            renValid <= 1'b0;
        end else begin
            renValid <= dec.valid;
        end
    end

    // Rename-stage output register
    always_ff @(posedge clk) begin
        srcPhys1   <= lookup1;
        srcPhys2   <= lookup2;
        src1Ready  <= ready1;
        src2Ready  <= ready2;
        destPhys   <= doAlloc ? newPhys : '0;
        renPc      <= dec.pc;
        renImm     <= dec.imm;
        renAluOp   <= dec.aluOp;
        renIllegal <= dec.illegal;
    end

endmodule

/* hdl/decodeUnit.sv */
`timescale 1ns/1ps
`include "frontEnd_defs.svh"

module decodeUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [31:0]             fetchWord,
    output logic [`IMEM_ADDR_W-1:0] fetchAddr,
    output logic                    running,
    decodeIf.decoder                dec
);

    logic [`IMEM_ADDR_W-1:0] pc;
    logic [`IMEM_ADDR_W-1:0] fetchPc;   // Address of the word on fetchWord
    logic                    fetchValid;
    logic                    stopNow;
    frontEndPkg::instrU      instr;

    logic [31:0]             immNext;
    frontEndPkg::aluOpE      aluOpNext;
    logic                    illegalNext;
    logic                    useRs2Next;
    logic                    regWriteNext;
    logic                    aluSrcNext;
    logic                    branchNext;
    logic                    memReadNext;
    logic                    memWriteNext;

    assign fetchAddr = pc;
    assign instr     = fetchWord;
    assign stopNow   = fetchValid && (fetchWord == 32'b0); // All-zero word ends the program

    // PC and fetch tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= '0;
            running    <= 1'b0;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= running && !stopNow; // Drops the word fetched after the stop word
            if (start) begin
                pc      <= '0;
                running <= 1'b1;
            end else if (running) begin
                if (stopNow || pc == `IMEM_DEPTH - 1) begin
                    running <= 1'b0;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        fetchPc <= pc;
    end

    always_comb begin
        immNext      = 32'b0;
        aluOpNext    = frontEndPkg::ADD;
        illegalNext  = 1'b0;
        useRs2Next   = 1'b0;
        regWriteNext = 1'b0;
        aluSrcNext   = 1'b0;
        branchNext   = 1'b0;
        memReadNext  = 1'b0;
        memWriteNext = 1'b0;
        case (instr.rType.opcode)
            frontEndPkg::OP: begin
                aluOpNext    = frontEndPkg::FUNCT;
                useRs2Next   = 1'b1;
                regWriteNext = 1'b1;
            end
            frontEndPkg::OPIMM: begin
                immNext      = {{20{instr.iType.imm[11]}}, instr.iType.imm};
                aluOpNext    = frontEndPkg::FUNCT;
                aluSrcNext   = 1'b1;
                regWriteNext = 1'b1;
            end
            frontEndPkg::LOAD: begin
                immNext      = {{20{instr.iType.imm[11]}}, instr.iType.imm};
                aluSrcNext   = 1'b1;
                regWriteNext = 1'b1;
                memReadNext  = 1'b1;
            end
            frontEndPkg::STORE: begin
                immNext      = {{20{instr.sType.immHi[6]}}, instr.sType.immHi,
                                instr.sType.immLo};
                aluSrcNext   = 1'b1;
                useRs2Next   = 1'b1;
                memWriteNext = 1'b1;
            end
            frontEndPkg::BRANCH: begin
                // B immediate rebuilt from the S fields
                immNext    = {{20{instr.sType.immHi[6]}}, instr.sType.immLo[0],
                              instr.sType.immHi[5:0], instr.sType.immLo[4:1], 1'b0};
                aluOpNext  = frontEndPkg::SUB;
                useRs2Next = 1'b1;
                branchNext = 1'b1;
            end
            frontEndPkg::LUI: begin
                immNext      = {instr.uType.imm, 12'b0};
                aluSrcNext   = 1'b1;
                regWriteNext = 1'b1;
            end
            default: begin
                illegalNext = 1'b1; // No write for unknown opcodes
            end
        endcase
    end

    // Decode-stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= fetchValid && !stopNow;
        end
    end

    always_ff @(posedge clk) begin
        dec.pc       <= {{(30 - `IMEM_ADDR_W){1'b0}}, fetchPc, 2'b00}; // Byte address
        dec.illegal  <= illegalNext;
        dec.rs1      <= instr.rType.rs1;
        dec.rs2      <= instr.rType.rs2;
        dec.rd       <= instr.rType.rd;
        dec.useRs2   <= useRs2Next;
        dec.regWrite <= regWriteNext;
        dec.imm      <= immNext;
        dec.aluOp    <= aluOpNext;
        dec.aluSrc   <= aluSrcNext;
        dec.branch   <= branchNext;
        dec.memRead  <= memReadNext;
        dec.memWrite <= memWriteNext;
        dec.memToReg <= memReadNext;
    end

endmodule

/* hdl/instrMemory.sv */
`timescale 1ns/1ps
`include "frontEnd_defs.svh"

module instrMemory (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    loadEn,
    input  logic [`IMEM_ADDR_W-1:0] loadAddr,
    input  logic [31:0]             loadData,
    input  logic [`IMEM_ADDR_W-1:0] fetchAddr,
    output logic [31:0]             fetchWord
);

    logic [31:0] mem [`IMEM_DEPTH];

    // Testbench load port
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // Registered read, word shows up one cycle after the address
    always_ff @(posedge clk) begin
        if (reset) begin
            fetchWord <= 32'b0;
        end else begin
            fetchWord <= mem[fetchAddr];
        end
    end

endmodule

/* hdl/decodeIf.sv */
`timescale 1ns/1ps
`include "frontEnd_defs.svh"

interface decodeIf;
    logic                valid;    // One strobe per instruction
    logic [31:0]         pc;
    logic                illegal;
    logic [`ARCH_W-1:0]  rs1;
    logic [`ARCH_W-1:0]  rs2;
    logic [`ARCH_W-1:0]  rd;
    logic                useRs2;
    logic                regWrite;
    logic [31:0]         imm;
    frontEndPkg::aluOpE  aluOp;
    logic                aluSrc;
    logic                branch;
    logic                memRead;
    logic                memWrite;
    logic                memToReg;

    modport decoder (
        output valid, pc, illegal, rs1, rs2, rd, useRs2, regWrite,
               imm, aluOp, aluSrc, branch, memRead, memWrite, memToReg
    );

    modport renamer (
        input valid, pc, illegal, rs1, rs2, rd, useRs2, regWrite,
              imm, aluOp, aluSrc, branch, memRead, memWrite, memToReg
    );
endinterface

/* hdl/frontEndPkg.sv */
`include "frontEnd_defs.svh"

package frontEndPkg;

    // RV32I major opcodes handled by the front end
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011
    } opcodeE;

    typedef enum logic [1:0] {
        ADD   = 2'b00, // Address calc, LUI
        SUB   = 2'b01, // Branch compare
        FUNCT = 2'b10  // funct3/funct7 pick the op
    } aluOpE;

    typedef struct packed {
        logic [6:0]         funct7;
        logic [`ARCH_W-1:0] rs2;
        logic [`ARCH_W-1:0] rs1;
        logic [2:0]         funct3;
        logic [`ARCH_W-1:0] rd;
        opcodeE             opcode;
    } rTypeS;

    typedef struct packed {
        logic [11:0]        imm;
        logic [`ARCH_W-1:0] rs1;
        logic [2:0]         funct3;
        logic [`ARCH_W-1:0] rd;
        opcodeE             opcode;
    } iTypeS;

    typedef struct packed {
        logic [6:0]         immHi;
        logic [`ARCH_W-1:0] rs2;
        logic [`ARCH_W-1:0] rs1;
        logic [2:0]         funct3;
        logic [4:0]         immLo;
        opcodeE             opcode;
    } sTypeS; // Also the B layout, bits are shuffled in the decoder

    typedef struct packed {
        logic [19:0]        imm;
        logic [`ARCH_W-1:0] rd;
        opcodeE             opcode;
    } uTypeS;

    // One fetched word, several views
    typedef union packed {
        rTypeS rType;
        iTypeS iType;
        sTypeS sType;
        uTypeS uType;
    } instrU;

endpackage

/* hdl/frontEnd_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// Instruction memory geometry
`define IMEM_DEPTH  32
`define IMEM_ADDR_W 5

// Architectural and physical register files
`define ARCH_REGS   32
`define ARCH_W      5
`define PHYS_REGS   64
`define PHYS_W      6

// Free list covers every physical register above the architectural ones
`define FREE_DEPTH  (`PHYS_REGS - `ARCH_REGS)
`define FREE_W      5

`endif
